// ==== Makefile ====
# Verilator build and run of the pong testbench

SIM := obj_dir/pong_sim

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"
	@echo "  help   show this list"

test:
	verilator --binary --timing -j 0 --top-module pong_tb -f build.f -o pong_sim
	./$(SIM) | tee /dev/stderr | grep -qF "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

// ==== build.f ====
design/pong_pkg.sv
design/vga_timing.sv
design/paddle_ctrl.sv
design/ball_engine.sv
design/pixel_render.sv
design/pong_core.sv
design/tt_um_pong.sv
verification/pong_tb.sv

// ==== design/ball_engine.sv ====
`timescale 1ns/10ps
`default_nettype none

module ball_engine
  import pong_pkg::*;
#(
  parameter int H_ACTIVE = 640,
  parameter int V_ACTIVE = 480,
  parameter int PADDLE_H = 48
) (
  input  wire                 clk,
  input  wire                 rst_n,
  input  wire                 frame_tick,
  input  wire  [COORD_W-1:0]  left_y,
  input  wire  [COORD_W-1:0]  right_y,
  output logic [COORD_W-1:0]  ball_x,
  output logic [COORD_W-1:0]  ball_y
);

  localparam int CNT_W = $clog2(SERVE_FRAMES + 1);

  localparam logic [COORD_W-1:0] X_MAX     = COORD_W'(H_ACTIVE - BALL_SIZE);
  localparam logic [COORD_W-1:0] Y_MAX     = COORD_W'(V_ACTIVE - BALL_SIZE);
  localparam logic [COORD_W-1:0] X_CENTRE  = COORD_W'((H_ACTIVE - BALL_SIZE) / 2);
  localparam logic [COORD_W-1:0] Y_CENTRE  = COORD_W'((V_ACTIVE - BALL_SIZE) / 2);
  // Ball x where its edge touches a paddle face
  localparam logic [COORD_W-1:0] LEFT_HIT  = COORD_W'(PADDLE_MARGIN + PADDLE_W);
  localparam logic [COORD_W-1:0] RIGHT_HIT =
    COORD_W'(H_ACTIVE - PADDLE_MARGIN - PADDLE_W - BALL_SIZE);
  localparam logic [COORD_W-1:0] BALL_SZ   = COORD_W'(BALL_SIZE);
  localparam logic [COORD_W-1:0] PAD_H     = COORD_W'(PADDLE_H);

  game_state_t      state;
  logic [CNT_W-1:0] serve_cnt;
  // Direction flags where 1 means right or down
  logic             dir_x;
  logic             dir_y;

  logic             dx;
  logic             dy;
  logic             hit_left;
  logic             hit_right;
  logic             miss;

  // Bounce and miss decisions on the current position
  always_comb begin
    hit_left  = (ball_y + BALL_SZ > left_y) && (ball_y < left_y + PAD_H);
    hit_right = (ball_y + BALL_SZ > right_y) && (ball_y < right_y + PAD_H);
    dx = dir_x;
    dy = dir_y;
    // Top and bottom walls
    if ((ball_y == '0 && !dir_y) || (ball_y == Y_MAX && dir_y)) begin
      dy = !dir_y;
    end
    if (!dir_x && ball_x == LEFT_HIT && hit_left) begin
      dx = 1'b1;
    end
    if (dir_x && ball_x == RIGHT_HIT && hit_right) begin
      dx = 1'b0;
    end
    miss = (ball_x == '0 && !dir_x) || (ball_x == X_MAX && dir_x);
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= SERVE;
      serve_cnt <= '0;
      dir_x     <= 1'b1;
      dir_y     <= 1'b1;
      ball_x    <= X_CENTRE;
      ball_y    <= Y_CENTRE;
    end else if (frame_tick) begin
      case (state)
        SERVE: begin
          // Ball holds still while waiting and on the last tick
          serve_cnt <= serve_cnt + 1'b1;
          if (serve_cnt + 1'b1 == CNT_W'(SERVE_FRAMES)) begin
            state <= PLAY;
          end
        end
        PLAY: begin
          if (miss) begin
            // Re-serve towards the player who just scored
            ball_x    <= X_CENTRE;
            ball_y    <= Y_CENTRE;
            dir_x     <= !dir_x;
            dir_y     <= dy;
            state     <= SERVE;
            serve_cnt <= '0;
          end else begin
            dir_x  <= dx;
            dir_y  <= dy;
            ball_x <= dx ? ball_x + 1'b1 : ball_x - 1'b1;
            ball_y <= dy ? ball_y + 1'b1 : ball_y - 1'b1;
          end
        end
        default: state <= SERVE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== design/paddle_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module paddle_ctrl
  import pong_pkg::*;
#(
  parameter int V_ACTIVE = 480,
  parameter int PADDLE_H = 48
) (
  input  wire                 clk,
  input  wire                 rst_n,
  input  wire                 frame_tick,
  input  buttons_t            btn,
  output logic [COORD_W-1:0]  pos_y
);

  // Lowest legal top row
  localparam logic [COORD_W-1:0] Y_MAX  = COORD_W'(V_ACTIVE - PADDLE_H);
  localparam logic [COORD_W-1:0] Y_INIT = COORD_W'((V_ACTIVE - PADDLE_H) / 2);
  localparam logic [COORD_W-1:0] STEP   = COORD_W'(PADDLE_STEP);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pos_y <= Y_INIT;
    end else if (frame_tick) begin
      // Both or neither pressed holds position
      if (btn.up && !btn.down) begin
        pos_y <= (pos_y < STEP) ? '0 : pos_y - STEP;
      end else if (btn.down && !btn.up) begin
        // Clamp at the bottom edge
        pos_y <= (pos_y + STEP > Y_MAX) ? Y_MAX : pos_y + STEP;
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/pixel_render.sv ====
`timescale 1ns/10ps
`default_nettype none

module pixel_render
  import pong_pkg::*;
#(
  parameter int H_ACTIVE = 640,
  parameter int PADDLE_H = 48
) (
  input  wire                 clk,
  input  wire                 rst_n,
  input  beam_t               beam,
  input  wire  [COORD_W-1:0]  left_y,
  input  wire  [COORD_W-1:0]  right_y,
  input  wire  [COORD_W-1:0]  ball_x,
  input  wire  [COORD_W-1:0]  ball_y,
  output video_t              video
);

  // Paddle columns where the right one mirrors the left
  localparam logic [COORD_W-1:0] LEFT_X0  = COORD_W'(PADDLE_MARGIN);
  localparam logic [COORD_W-1:0] LEFT_X1  = COORD_W'(PADDLE_MARGIN + PADDLE_W - 1);
  localparam logic [COORD_W-1:0] RIGHT_X0 = COORD_W'(H_ACTIVE - PADDLE_MARGIN - PADDLE_W);
  localparam logic [COORD_W-1:0] RIGHT_X1 = COORD_W'(H_ACTIVE - PADDLE_MARGIN - 1);
  localparam logic [COORD_W-1:0] BALL_SZ  = COORD_W'(BALL_SIZE);
  localparam logic [COORD_W-1:0] PAD_H    = COORD_W'(PADDLE_H);

  logic in_ball;
  logic in_left;
  logic in_right;
  rgb_t colour;

  always_comb begin
    in_ball  = (beam.x >= ball_x) && (beam.x < ball_x + BALL_SZ) &&
               (beam.y >= ball_y) && (beam.y < ball_y + BALL_SZ);
    in_left  = (beam.x >= LEFT_X0) && (beam.x <= LEFT_X1) &&
               (beam.y >= left_y) && (beam.y < left_y + PAD_H);
    in_right = (beam.x >= RIGHT_X0) && (beam.x <= RIGHT_X1) &&
               (beam.y >= right_y) && (beam.y < right_y + PAD_H);
    // Ball drawn over paddles
    if (!beam.active) begin
      colour = '0;
    end else if (in_ball) begin
      colour = BALL_COLOR;
    end else if (in_left) begin
      colour = LEFT_COLOR;
    end else if (in_right) begin
      colour = RIGHT_COLOR;
    end else begin
      colour = BG_COLOR;
    end
  end

  // Syncs delayed with the colour so they leave aligned
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      video <= '{colour: '0, hs: 1'b1, vs: 1'b1};
    end else begin
      video <= '{colour: colour, hs: beam.hs, vs: beam.vs};
    end
  end

endmodule

`default_nettype wire

// ==== design/pong_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module pong_core
  import pong_pkg::*;
#(
  parameter int H_ACTIVE = 640,
  parameter int H_FP     = 16,
  parameter int H_SYNC   = 96,
  parameter int H_BP     = 48,
  parameter int V_ACTIVE = 480,
  parameter int V_FP     = 10,
  parameter int V_SYNC   = 2,
  parameter int V_BP     = 33,
  parameter int PADDLE_H = 48
) (
  input  wire      clk,
  input  wire      rst_n,
  input  buttons_t left_btn,
  input  buttons_t right_btn,
  output video_t   video
);

  beam_t              beam;
  logic               frame_tick;
  logic [COORD_W-1:0] left_y;
  logic [COORD_W-1:0] right_y;
  logic [COORD_W-1:0] ball_x;
  logic [COORD_W-1:0] ball_y;

  // Raster generator
  vga_timing #(
    .H_ACTIVE(H_ACTIVE), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
    .V_ACTIVE(V_ACTIVE), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP)
  ) vga_timing_inst (
    .clk(clk), .rst_n(rst_n), .beam(beam), .frame_tick(frame_tick)
  );

  // Players
  paddle_ctrl #(.V_ACTIVE(V_ACTIVE), .PADDLE_H(PADDLE_H)) left_paddle_inst (
    .clk(clk), .rst_n(rst_n), .frame_tick(frame_tick), .btn(left_btn), .pos_y(left_y)
  );

  paddle_ctrl #(.V_ACTIVE(V_ACTIVE), .PADDLE_H(PADDLE_H)) right_paddle_inst (
    .clk(clk), .rst_n(rst_n), .frame_tick(frame_tick), .btn(right_btn), .pos_y(right_y)
  );

  // Ball sees paddle rows from before this tick
  ball_engine #(
    .H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE), .PADDLE_H(PADDLE_H)
  ) ball_engine_inst (
    .clk(clk), .rst_n(rst_n), .frame_tick(frame_tick),
    .left_y(left_y), .right_y(right_y), .ball_x(ball_x), .ball_y(ball_y)
  );

  pixel_render #(.H_ACTIVE(H_ACTIVE), .PADDLE_H(PADDLE_H)) pixel_render_inst (
    .clk(clk), .rst_n(rst_n), .beam(beam), .left_y(left_y), .right_y(right_y),
    .ball_x(ball_x), .ball_y(ball_y), .video(video)
  );

endmodule

`default_nettype wire

// ==== design/pong_pkg.sv ====
`default_nettype none

package pong_pkg;

  // Screen coordinate width covering the full 800 by 525 raster
  localparam int COORD_W = 10;

  // Twelve bit colour with four bits per channel
  typedef struct packed {
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
  } rgb_t;

  // Current beam position with its sync levels
  typedef struct packed {
    logic [COORD_W-1:0] x;
    logic [COORD_W-1:0] y;
    logic               active;
    logic               hs;
    logic               vs;
  } beam_t;

  // One output pixel with colour and syncs
  typedef struct packed {
    rgb_t colour;
    logic hs;
    logic vs;
  } video_t;

  // Controls of one player
  typedef struct packed {
    logic up;
    logic down;
  } buttons_t;

  // Ball engine states
  typedef enum logic [0:0] {
    SERVE = 1'b0,
    PLAY  = 1'b1
  } game_state_t;

  // Playfield geometry in pixels
  localparam int PADDLE_W      = 4;
  localparam int PADDLE_MARGIN = 4;
  localparam int BALL_SIZE     = 4;
  localparam int PADDLE_STEP   = 2;
  // Frames the ball rests at centre before play
  localparam int SERVE_FRAMES  = 2;

  // Palette
  localparam rgb_t LEFT_COLOR  = '{r: 4'hF, g: 4'h0, b: 4'h0};
  localparam rgb_t RIGHT_COLOR = '{r: 4'h0, g: 4'h0, b: 4'hF};
  localparam rgb_t BALL_COLOR  = '{r: 4'hF, g: 4'hF, b: 4'hF};
  localparam rgb_t BG_COLOR    = '{r: 4'h0, g: 4'h0, b: 4'h0};

endpackage

`default_nettype wire

// ==== design/tt_um_pong.sv ====
`timescale 1ns/10ps
`default_nettype none

module tt_um_pong
  import pong_pkg::*;
#(
  parameter int H_ACTIVE = 640,
  parameter int H_FP     = 16,
  parameter int H_SYNC   = 96,
  parameter int H_BP     = 48,
  parameter int V_ACTIVE = 480,
  parameter int V_FP     = 10,
  parameter int V_SYNC   = 2,
  parameter int V_BP     = 33,
  parameter int PADDLE_H = 48
) (
  input  wire [7:0] ui_in,
  output wire [7:0] uo_out,
  input  wire [7:0] uio_in,
  output wire [7:0] uio_out,
  output wire [7:0] uio_oe,
  input  wire       ena,
  input  wire       clk,
  input  wire       rst_n
);

  buttons_t left_btn;
  buttons_t right_btn;
  video_t   video;
  logic     vga_sel;

  // Input pmod with two buttons per player
  assign left_btn  = '{up: ui_in[0], down: ui_in[1]};
  assign right_btn = '{up: ui_in[2], down: ui_in[3]};
  // Selects the output pmod wiring
  assign vga_sel   = ui_in[7];

  pong_core #(
    .H_ACTIVE(H_ACTIVE), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
    .V_ACTIVE(V_ACTIVE), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP),
    .PADDLE_H(PADDLE_H)
  ) pong_core_inst (
    .clk(clk), .rst_n(rst_n), .left_btn(left_btn), .right_btn(right_btn), .video(video)
  );

  // Sel 1 drives the single 2 bit pmod and sel 0 splits red and blue here
  assign uo_out = vga_sel ?
    {video.hs, video.colour.b[0], video.colour.g[0], video.colour.r[0],
     video.vs, video.colour.b[1], video.colour.g[1], video.colour.r[1]} :
    {video.colour.b, video.colour.r};
  // Green and syncs on the bidirectional pmod which is only driven for sel 0
  assign uio_out = {2'b00, video.vs, video.hs, video.colour.g};
  assign uio_oe  = vga_sel ? 8'h00 : 8'hFF;

endmodule

`default_nettype wire

// ==== design/vga_timing.sv ====
`timescale 1ns/10ps
`default_nettype none

module vga_timing
  import pong_pkg::*;
#(
  parameter int H_ACTIVE = 640,
  parameter int H_FP     = 16,
  parameter int H_SYNC   = 96,
  parameter int H_BP     = 48,
  parameter int V_ACTIVE = 480,
  parameter int V_FP     = 10,
  parameter int V_SYNC   = 2,
  parameter int V_BP     = 33
) (
  input  wire   clk,
  input  wire   rst_n,
  output beam_t beam,
  output logic  frame_tick
);

  localparam int H_TOTAL = H_ACTIVE + H_FP + H_SYNC + H_BP;
  localparam int V_TOTAL = V_ACTIVE + V_FP + V_SYNC + V_BP;

  // Sync windows for the active low pulses
  localparam logic [COORD_W-1:0] HS_START = COORD_W'(H_ACTIVE + H_FP);
  localparam logic [COORD_W-1:0] HS_END   = COORD_W'(H_ACTIVE + H_FP + H_SYNC);
  localparam logic [COORD_W-1:0] VS_START = COORD_W'(V_ACTIVE + V_FP);
  localparam logic [COORD_W-1:0] VS_END   = COORD_W'(V_ACTIVE + V_FP + V_SYNC);

  logic [COORD_W-1:0] x_nxt;
  logic [COORD_W-1:0] y_nxt;

  // Next beam position wrapping at end of line and end of frame
  always_comb begin
    x_nxt = beam.x + 1'b1;
    y_nxt = beam.y;
    if (beam.x == COORD_W'(H_TOTAL - 1)) begin
      x_nxt = '0;
      if (beam.y == COORD_W'(V_TOTAL - 1)) begin
        y_nxt = '0;
      end else begin
        y_nxt = beam.y + 1'b1;
      end
    end
  end

  // Flags derived from the next position so they line up with the counters
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      beam       <= '{x: '0, y: '0, active: 1'b1, hs: 1'b1, vs: 1'b1};
      frame_tick <= 1'b0;
    end else begin
      beam.x      <= x_nxt;
      beam.y      <= y_nxt;
      beam.active <= (x_nxt < COORD_W'(H_ACTIVE)) && (y_nxt < COORD_W'(V_ACTIVE));
      beam.hs     <= !((x_nxt >= HS_START) && (x_nxt < HS_END));
      beam.vs     <= !((y_nxt >= VS_START) && (y_nxt < VS_END));
      // First blanking line starts the vertical retrace window
      frame_tick  <= (x_nxt == '0) && (y_nxt == COORD_W'(V_ACTIVE));
    end
  end

endmodule

`default_nettype wire

// ==== verification/pong_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module pong_tb;

  // Shrunken raster to keep frames short
  localparam int H_ACTIVE = 64;
  localparam int H_FP     = 4;
  localparam int H_SYNC   = 8;
  localparam int H_BP     = 4;
  localparam int V_ACTIVE = 48;
  localparam int V_FP     = 2;
  localparam int V_SYNC   = 2;
  localparam int V_BP     = 2;
  localparam int PADDLE_H = 12;
  localparam int H_TOTAL  = H_ACTIVE + H_FP + H_SYNC + H_BP;
  localparam int V_TOTAL  = V_ACTIVE + V_FP + V_SYNC + V_BP;
  localparam int FRAMES   = 300;
  // Model geometry
  localparam int P_MAX    = V_ACTIVE - PADDLE_H;
  localparam int BX_MAX   = H_ACTIVE - 4;
  localparam int BY_MAX   = V_ACTIVE - 4;

  logic       clk;
  logic       rst_n;
  logic [7:0] ui_in;
  logic [7:0] uio_in;
  logic       ena;
  wire  [7:0] uo_out;
  wire  [7:0] uio_out;
  wire  [7:0] uio_oe;

  // Game model state
  int left_y_m;
  int right_y_m;
  int ball_x_m;
  int ball_y_m;
  int dir_right;
  int dir_down;
  int serving;
  int serve_cnt_m;

  tt_um_pong #(
    .H_ACTIVE(H_ACTIVE), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
    .V_ACTIVE(V_ACTIVE), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP),
    .PADDLE_H(PADDLE_H)
  ) tt_um_pong_inst (
    .ui_in(ui_in), .uo_out(uo_out), .uio_in(uio_in), .uio_out(uio_out),
    .uio_oe(uio_oe), .ena(ena), .clk(clk), .rst_n(rst_n)
  );

  always #5 clk = ~clk;

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_val(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    if (expected !== actual) begin
      abort_run($sformatf("mismatch %s: expected 0x%0h, got 0x%0h", name, expected, actual));
    end
  endtask

  // Sync levels as seen on the selected pinout
  function automatic logic pin_hs();
    return ui_in[7] ? uo_out[7] : uio_out[4];
  endfunction

  function automatic logic pin_vs();
    return ui_in[7] ? uo_out[3] : uio_out[5];
  endfunction

  function automatic int move_paddle(input int p, input logic up, input logic down);
    if (up && !down) begin
      p = (p < 2) ? 0 : p - 2;
    end else if (down && !up) begin
      p = (p + 2 > P_MAX) ? P_MAX : p + 2;
    end
    return p;
  endfunction

  function automatic logic rows_overlap(input int y, input int p);
    return (y + 4 > p) && (y < p + PADDLE_H);
  endfunction

  // One frame tick where the ball sees paddle rows from before the tick
  task automatic step_model();
    int ndx;
    int ndy;
    if (serving == 1) begin
      serve_cnt_m++;
      if (serve_cnt_m == 2) begin
        serving = 0;
      end
    end else begin
      ndx = dir_right;
      ndy = dir_down;
      if ((ball_y_m == 0 && dir_down == 0) || (ball_y_m == BY_MAX && dir_down == 1)) begin
        ndy = 1 - dir_down;
      end
      if (dir_right == 0 && ball_x_m == 8 && rows_overlap(ball_y_m, left_y_m)) begin
        ndx = 1;
      end
      if (dir_right == 1 && ball_x_m + 4 == H_ACTIVE - 8 &&
          rows_overlap(ball_y_m, right_y_m)) begin
        ndx = 0;
      end
      if ((ball_x_m == 0 && dir_right == 0) || (ball_x_m == BX_MAX && dir_right == 1)) begin
        // Miss sends the ball back to centre to serve the other way
        ball_x_m    = BX_MAX / 2;
        ball_y_m    = BY_MAX / 2;
        dir_right   = 1 - dir_right;
        dir_down    = ndy;
        serving     = 1;
        serve_cnt_m = 0;
      end else begin
        dir_right = ndx;
        dir_down  = ndy;
        ball_x_m  = (ndx == 1) ? ball_x_m + 1 : ball_x_m - 1;
        ball_y_m  = (ndy == 1) ? ball_y_m + 1 : ball_y_m - 1;
      end
    end
    left_y_m  = move_paddle(left_y_m, ui_in[0], ui_in[1]);
    right_y_m = move_paddle(right_y_m, ui_in[2], ui_in[3]);
  endtask

  // Expected colour as r, g, b nibbles
  function automatic int pixel_colour(input int x, input int y);
    if (x >= H_ACTIVE || y >= V_ACTIVE) return 0;
    if (x >= ball_x_m && x < ball_x_m + 4 && y >= ball_y_m && y < ball_y_m + 4) return 'hFFF;
    if (x >= 4 && x < 8 && y >= left_y_m && y < left_y_m + PADDLE_H) return 'hF00;
    if (x >= H_ACTIVE - 8 && x < H_ACTIVE - 4 && y >= right_y_m &&
        y < right_y_m + PADDLE_H) return 'h00F;
    return 0;
  endfunction

  task automatic check_pins(input int c, input logic hs, input logic vs);
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
    r = 4'(c >> 8);
    g = 4'(c >> 4);
    b = 4'(c);
    if (ui_in[7]) begin
      check_val("uo_out", 32'({hs, b[0], g[0], r[0], vs, b[1], g[1], r[1]}), 32'(uo_out));
      check_val("uio_oe", 32'h00, 32'(uio_oe));
      check_val("uio_out[7:6]", 32'h0, 32'(uio_out[7:6]));
    end else begin
      check_val("uo_out", 32'({b, r}), 32'(uo_out));
      check_val("uio_out", 32'({2'b00, vs, hs, g}), 32'(uio_out));
      check_val("uio_oe", 32'hFF, 32'(uio_oe));
    end
  endtask

  task automatic wait_vs_rise();
    logic prev;
    logic cur;
    logic found;
    int   n;
    prev  = pin_vs();
    found = 1'b0;
    n     = 0;
    while (!found && n < 2 * H_TOTAL * V_TOTAL) begin
      @(negedge clk);
      cur   = pin_vs();
      found = cur && !prev;
      prev  = cur;
      n++;
    end
    if (!found) abort_run("timeout: vs rising edge never came after reset");
  endtask

  initial begin
    int         seed;
    int         cx;
    int         cy;
    int         frames;
    int         hs_low;
    int         vs_low;
    int         since_hs;
    int         since_vs;
    logic       hs;
    logic       vs;
    logic       prev_hs;
    logic       prev_vs;
    logic       load_ui;
    logic [3:0] btns;
    logic [7:0] next_ui;
    seed   = $urandom(90);
    clk    = 1'b0;
    rst_n  = 1'b0;
    ui_in  = 8'h00;
    uio_in = 8'h00;
    ena    = 1'b1;
    // Reset state of the game
    left_y_m    = P_MAX / 2;
    right_y_m   = P_MAX / 2;
    ball_x_m    = BX_MAX / 2;
    ball_y_m    = BY_MAX / 2;
    dir_right   = 1;
    dir_down    = 1;
    serving     = 1;
    serve_cnt_m = 0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    wait_vs_rise();
    // Tick of the first frame already passed with idle buttons
    step_model();
    cx       = 0;
    cy       = V_ACTIVE + V_FP + V_SYNC;
    prev_hs  = 1'b1;
    prev_vs  = 1'b1;
    hs_low   = 0;
    vs_low   = 0;
    since_hs = 0;
    since_vs = 0;
    frames   = 0;
    load_ui  = 1'b0;
    btns     = 4'h0;
    next_ui  = 8'h00;
    while (frames < FRAMES) begin
      @(posedge clk);
      if (load_ui) begin
        ui_in   <= next_ui;
        load_ui = 1'b0;
      end
      @(negedge clk);
      cx++;
      if (cx == H_TOTAL) begin
        cx = 0;
        cy = (cy == V_TOTAL - 1) ? 0 : cy + 1;
      end
      hs = pin_hs();
      vs = pin_vs();
      since_hs++;
      since_vs++;
      if (!hs) hs_low++;
      if (!vs) vs_low++;
      // Rising edges close each sync pulse
      if (hs && !prev_hs) begin
        check_val("hs_low_cycles", H_SYNC, hs_low);
        check_val("hs_rise_x", H_ACTIVE + H_FP + H_SYNC, cx);
        hs_low   = 0;
        since_hs = 0;
      end
      if (vs && !prev_vs) begin
        check_val("vs_low_cycles", V_SYNC * H_TOTAL, vs_low);
        check_val("vs_rise_y", V_ACTIVE + V_FP + V_SYNC, cy);
        vs_low   = 0;
        since_vs = 0;
      end
      if (since_hs > H_TOTAL) abort_run("timeout: hs rising edge never came within a line");
      if (since_vs > H_TOTAL * V_TOTAL) abort_run("timeout: vs rising edge never came");
      check_pins(pixel_colour(cx, cy),
                 !(cx >= H_ACTIVE + H_FP && cx < H_ACTIVE + H_FP + H_SYNC),
                 !(cy >= V_ACTIVE + V_FP && cy < V_ACTIVE + V_FP + V_SYNC));
      // New buttons and pinout right after vs falls and held through the next tick
      if (!vs && prev_vs) begin
        if ($urandom % 8 == 0) btns = 4'($urandom);
        next_ui = {1'($urandom), 3'b000, btns};
        load_ui = 1'b1;
      end
      // Captured pixel one past the frame tick
      if (cx == 0 && cy == V_ACTIVE) begin
        step_model();
        frames++;
      end
      prev_hs = hs;
      prev_vs = vs;
    end
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire
